// File: source/freq_gen_pkg.sv
// Shared sizes, register map and vector types for the multi-channel clock-strobe generator.
package freq_gen_pkg;

    // ********************************************************
    // Sizes
    // ********************************************************
    localparam int NUM_CHAN = 4;
    localparam int DIV_W    = 8;
    localparam int ADDR_W   = 3;
    localparam int CNT_W    = 16;

    // Divider value, loaded as half period minus one.
    typedef logic [DIV_W-1:0]            div_t;
    // One bit per channel, for enables and wave outputs.
    typedef logic [NUM_CHAN-1:0]         chan_mask_t;
    typedef logic [$clog2(NUM_CHAN)-1:0] chan_idx_t;
    typedef logic [ADDR_W-1:0]           reg_addr_t;
    typedef logic [CNT_W-1:0]            edge_cnt_t;

    // ********************************************************
    // Register map
    // ********************************************************
    // Addresses 0 to NUM_CHAN-1 hold the channel dividers.
    // Addresses above the enable mask are reserved and ignored.
    localparam reg_addr_t EN_ADDR = reg_addr_t'(4);

endpackage

// File: source/freq_cfg_regs.sv
// Write-only configuration registers holding per-channel divider values and the enable mask.
`timescale 1ns/10ps

module freq_cfg_regs (
    input  logic                                              master_clk,
    input  logic                                              rstn,
    input  logic                                              wr_en,
    input  freq_gen_pkg::reg_addr_t                           wr_addr,
    input  freq_gen_pkg::div_t                                wr_data,
    output freq_gen_pkg::div_t [freq_gen_pkg::NUM_CHAN-1:0]   div_val,
    output freq_gen_pkg::chan_mask_t                          chan_en
);

    import freq_gen_pkg::*;

    // Per-register write strobes from the address decode.
    logic [NUM_CHAN-1:0] div_we;
    logic                en_we;

    // ********************************************************
    // Address decode
    // ********************************************************
    // Each divider register owns one address; the reserved
    // addresses above the enable mask match nothing here.
    always_comb begin
        for (int i = 0; i < NUM_CHAN; i++) begin
            div_we[i] = wr_en && (wr_addr == reg_addr_t'(i));
        end
        en_we = wr_en && (wr_addr == EN_ADDR);
    end

    // ********************************************************
    // Divider registers
    // ********************************************************
    // A new value is visible to the channels from the cycle
    // after the write strobe.
    always_ff @(posedge master_clk or negedge rstn) begin
        if (!rstn) begin
            div_val <= '0;
        end else begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (div_we[i]) begin
                    div_val[i] <= wr_data;
                end
            end
        end
    end

    // ********************************************************
    // Enable mask
    // ********************************************************
    // Only the low NUM_CHAN data bits carry enables.
    always_ff @(posedge master_clk or negedge rstn) begin
        if (!rstn) begin
            chan_en <= '0;
        end else if (en_we) begin
            chan_en <= wr_data[NUM_CHAN-1:0];
        end
    end

endmodule

// File: source/freq_divider_chan.sv
// Single divider channel producing a 50 percent square wave with a programmable half period.
`timescale 1ns/10ps

module freq_divider_chan (
    input  logic               master_clk,
    input  logic               rstn,
    input  freq_gen_pkg::div_t div_val,
    input  logic               enable,
    output logic               wave
);

    import freq_gen_pkg::*;

    // Cycle counter within the running half period.
    div_t cnt;
    // Divider in force for the running half period.
    div_t div_act;
    logic at_end;

    // The compare is used in the same cycle, so a half period
    // lasts exactly div_act + 1 master clock cycles.
    assign at_end = (cnt == div_act);

    // ********************************************************
    // Half period counter
    // ********************************************************
    always_ff @(posedge master_clk or negedge rstn) begin
        if (!rstn) begin
            cnt <= '0;
        end else if (!enable) begin
            cnt <= '0;
        end else if (at_end) begin
            cnt <= '0;
        end else begin
            cnt <= cnt + div_t'(1);
        end
    end

    // ********************************************************
    // Active divider copy
    // ********************************************************
    // While the channel is off the copy tracks the register, so
    // the first half period after enable uses the current value.
    // Once running, it only reloads at a toggle; a write in the
    // middle of a half period never shortens or stretches it.
    always_ff @(posedge master_clk or negedge rstn) begin
        if (!rstn) begin
            div_act <= '0;
        end else if (!enable || at_end) begin
            div_act <= div_val;
        end
    end

    // ********************************************************
    // Wave register
    // ********************************************************
    // Dropping the enable forces the output low at the next edge.
    always_ff @(posedge master_clk or negedge rstn) begin
        if (!rstn) begin
            wave <= 1'b0;
        end else if (!enable) begin
            wave <= 1'b0;
        end else if (at_end) begin
            wave <= ~wave;
        end
    end

endmodule

// File: source/clk_out_monitor.sv
// Output stage that registers all channel waves and counts rising edges on one selected channel.
`timescale 1ns/10ps

module clk_out_monitor (
    input  logic                     master_clk,
    input  logic                     rstn,
    input  freq_gen_pkg::chan_mask_t chan_wave,
    input  freq_gen_pkg::chan_idx_t  mon_sel,
    input  logic                     cnt_clr,
    output freq_gen_pkg::chan_mask_t chan_clk,
    output freq_gen_pkg::edge_cnt_t  edge_count
);

    import freq_gen_pkg::*;

    // Previous value of each registered wave, kept for every
    // channel so the edge detect never mixes two channels.
    chan_mask_t clk_prev;
    chan_mask_t rise;
    logic       sel_rise;

    // ********************************************************
    // Output registers
    // ********************************************************
    always_ff @(posedge master_clk or negedge rstn) begin
        if (!rstn) begin
            chan_clk <= '0;
            clk_prev <= '0;
        end else begin
            chan_clk <= chan_wave;
            clk_prev <= chan_clk;
        end
    end

    // Rising edges are found per channel before the select, so
    // switching mon_sel cannot look like an edge.
    assign rise     = chan_clk & ~clk_prev;
    assign sel_rise = rise[mon_sel];

    // ********************************************************
    // Edge counter
    // ********************************************************
    // Clear wins over a count in the same cycle.
    // The count sticks at all ones rather than wrapping.
    always_ff @(posedge master_clk or negedge rstn) begin
        if (!rstn) begin
            edge_count <= '0;
        end else if (cnt_clr) begin
            edge_count <= '0;
        end else if (sel_rise && (edge_count != '1)) begin
            edge_count <= edge_count + edge_cnt_t'(1);
        end
    end

endmodule

// File: source/multi_freq_gen.sv
// Top level of the four-channel clock-strobe generator with register file, dividers and monitor.
`timescale 1ns/10ps

module multi_freq_gen (
    input  logic                     master_clk,
    input  logic                     rstn,
    input  logic                     wr_en,
    input  freq_gen_pkg::reg_addr_t  wr_addr,
    input  freq_gen_pkg::div_t       wr_data,
    input  freq_gen_pkg::chan_idx_t  mon_sel,
    input  logic                     cnt_clr,
    output freq_gen_pkg::chan_mask_t chan_clk,
    output freq_gen_pkg::edge_cnt_t  edge_count
);

    import freq_gen_pkg::*;

    div_t [NUM_CHAN-1:0] div_val;
    chan_mask_t          chan_en;
    chan_mask_t          chan_wave;

    // ********************************************************
    // Configuration
    // ********************************************************
    freq_cfg_regs u_cfg (
        .master_clk (master_clk),
        .rstn       (rstn),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .div_val    (div_val),
        .chan_en    (chan_en)
    );

    // ********************************************************
    // Divider channels
    // ********************************************************
    // All channels run from the same master clock and are
    // not phase aligned to each other.
    for (genvar i = 0; i < NUM_CHAN; i++) begin : g_chan
        freq_divider_chan u_div (
            .master_clk (master_clk),
            .rstn       (rstn),
            .div_val    (div_val[i]),
            .enable     (chan_en[i]),
            .wave       (chan_wave[i])
        );
    end

    // ********************************************************
    // Output stage
    // ********************************************************
    clk_out_monitor u_mon (
        .master_clk (master_clk),
        .rstn       (rstn),
        .chan_wave  (chan_wave),
        .mon_sel    (mon_sel),
        .cnt_clr    (cnt_clr),
        .chan_clk   (chan_clk),
        .edge_count (edge_count)
    );

endmodule

// File: include/tb_freq_model.svh
// Reference model of expected edge counts and the value compare used by the testbench.
`ifndef TB_FREQ_MODEL_SVH
`define TB_FREQ_MODEL_SVH

// ************************************************************
// Reference model
// ************************************************************

// Number of rising edges seen in a window of the given length.
// The window is assumed to start right after a rising edge, so
// a full period of 2 * (div + 1) cycles is needed per edge.
function automatic int expected_edges(input int window_cycles, input int div);
    int period;
    period = 2 * (div + 1);
    if (window_cycles <= 0) begin
        return 0;
    end
    return window_cycles / period;
endfunction

// ************************************************************
// Compare
// ************************************************************

// Stops the run on the first mismatch.
task automatic check_val(
    input string   name,
    input longint  exp_val,
    input longint  act_val
);
    if (exp_val != act_val) begin
        $display("ERR @%0t %s expected %0d actual %0d",
                 $time, name, exp_val, act_val);
        $display("Test FAILED");
        $fatal(1, "mismatch on %s", name);
    end
endtask

`endif

// File: tests/tb_multi_freq_gen.sv
// Testbench for the four-channel clock-strobe generator, checking periods, enables and edge counts.
`timescale 1ns/10ps

module tb_multi_freq_gen;

    import freq_gen_pkg::*;

    `include "tb_freq_model.svh"

    // Test windows in master clock cycles.
    localparam int MAX_PERIOD  = 2 * 256;
    localparam int SETUP_CYC   = 64;
    localparam int INIT_WIN    = 20;
    localparam int RUN_WIN     = 800;
    localparam int CHG_TOG     = 6;
    localparam int OFF_WIN     = 40;
    localparam int CNT_WIN     = 300;
    localparam int SEL_WIN     = 150;
    localparam int SEL_N       = 6;
    localparam int TIMEOUT_CYC = 2 * (SETUP_CYC + INIT_WIN + RUN_WIN
                                      + CHG_TOG * MAX_PERIOD / 2 + OFF_WIN + MAX_PERIOD
                                      + 2 * (CNT_WIN + MAX_PERIOD)
                                      + SEL_N * (SEL_WIN + MAX_PERIOD));

    logic       master_clk;
    logic       rstn;
    logic       wr_en;
    reg_addr_t  wr_addr;
    div_t       wr_data;
    chan_idx_t  mon_sel;
    logic       cnt_clr;
    chan_mask_t chan_clk;
    edge_cnt_t  edge_count;

    // Expected register contents and per-channel measurement state.
    int         cyc;
    int         seed;
    int         model_div [NUM_CHAN];
    bit         en_model  [NUM_CHAN];
    bit         running   [NUM_CHAN];
    int         act_div   [NUM_CHAN];
    int         last_tog  [NUM_CHAN];
    int         first_tog [NUM_CHAN];
    int         rise_cyc  [NUM_CHAN];
    int         n_chk     [NUM_CHAN];
    chan_mask_t prev_clk;

    multi_freq_gen u_dut (
        .master_clk (master_clk),
        .rstn       (rstn),
        .wr_en      (wr_en),
        .wr_addr    (wr_addr),
        .wr_data    (wr_data),
        .mon_sel    (mon_sel),
        .cnt_clr    (cnt_clr),
        .chan_clk   (chan_clk),
        .edge_count (edge_count)
    );

    initial begin
        master_clk = 1'b0;
        forever #4 master_clk = ~master_clk;
    end

    // ********************************************************
    // Period checker
    // ********************************************************
    // Outputs are read before the edge updates them. A toggle seen
    // here happened on chan_clk one cycle earlier, so spacing is exact.
    always @(posedge master_clk) begin
        if (rstn) begin
            for (int i = 0; i < NUM_CHAN; i++) begin
                if (chan_clk[i] !== prev_clk[i]) begin
                    if (chan_clk[i] === 1'b1) begin
                        rise_cyc[i] = cyc;
                    end
                    if (en_model[i]) begin
                        if (running[i]) begin
                            check_val($sformatf("chan_clk[%0d] half period", i),
                                      act_div[i] + 1, cyc - last_tog[i]);
                            n_chk[i] = n_chk[i] + 1;
                        end else begin
                            running[i]   = 1'b1;
                            first_tog[i] = cyc;
                        end
                        // The channel reloads its divider at every toggle.
                        act_div[i]  = model_div[i];
                        last_tog[i] = cyc;
                    end
                end
            end
            prev_clk = chan_clk;
        end
        cyc = cyc + 1;
        if (cyc > TIMEOUT_CYC) begin
            $display("Timeout: the run did not finish within %0d cycles", TIMEOUT_CYC);
            $display("Test FAILED");
            $fatal(1, "timeout");
        end
    end

    // ********************************************************
    // Stimulus tasks
    // ********************************************************
    task automatic write_reg(input reg_addr_t addr, input div_t data, output int wcyc);
        @(negedge master_clk);
        wr_en   = 1'b1;
        wr_addr = addr;
        wr_data = data;
        wcyc    = cyc;
        if (addr < NUM_CHAN) begin
            model_div[addr] = data;
        end
        @(negedge master_clk);
        wr_en = 1'b0;
    endtask

    task automatic wait_toggle(input int ch);
        int snap;
        snap = last_tog[ch];
        do begin
            @(negedge master_clk);
        end while (last_tog[ch] == snap);
    endtask

    task automatic wait_rise(input int ch);
        int snap;
        snap = rise_cyc[ch];
        do begin
            @(negedge master_clk);
        end while (rise_cyc[ch] == snap);
    endtask

    // Clear the counter right after a rising edge, then count over a window.
    task automatic count_window(input int ch, input int win);
        @(negedge master_clk);
        mon_sel = chan_idx_t'(ch);
        wait_rise(ch);
        cnt_clr = 1'b1;
        repeat (win) begin
            @(negedge master_clk);
            cnt_clr = 1'b0;
        end
    endtask

    initial begin
        int w;
        int exp_cnt;
        int ch;
        int tog_ref;
        int old_div;
        rstn    = 1'b0;
        wr_en   = 1'b0;
        wr_addr = '0;
        wr_data = '0;
        mon_sel = '0;
        cnt_clr = 1'b0;
        cyc      = 0;
        seed     = 32'h62f0;
        prev_clk = '0;
        for (int i = 0; i < NUM_CHAN; i++) begin
            model_div[i] = 0;
            en_model[i]  = 1'b0;
            running[i]   = 1'b0;
            act_div[i]   = 0;
            last_tog[i]  = -1;
            first_tog[i] = -1;
            rise_cyc[i]  = -1;
            n_chk[i]     = 0;
        end
        repeat (3) @(posedge master_clk);
        @(negedge master_clk);
        rstn = 1'b1;

        // Idle after reset, dividers loaded but nothing enabled.
        write_reg(reg_addr_t'(0), div_t'(0), w);
        write_reg(reg_addr_t'(1), div_t'(255), w);
        write_reg(reg_addr_t'(2), div_t'(20), w);
        write_reg(reg_addr_t'(3), div_t'(5), w);
        repeat (INIT_WIN) begin
            @(negedge master_clk);
            check_val("chan_clk", 0, chan_clk);
            check_val("edge_count", 0, edge_count);
        end

        // All four channels run together.
        for (int i = 0; i < NUM_CHAN; i++) begin
            en_model[i] = 1'b1;
        end
        write_reg(EN_ADDR, div_t'(8'h0f), w);
        repeat (RUN_WIN) @(negedge master_clk);
        for (int i = 0; i < NUM_CHAN; i++) begin
            check_val($sformatf("chan_clk[%0d] period seen", i), 1, n_chk[i] > 0);
        end

        // Divider change in the middle of a half period on channel 2.
        wait_toggle(2);
        tog_ref = last_tog[2];
        old_div = model_div[2];
        repeat (5) @(negedge master_clk);
        write_reg(reg_addr_t'(2), div_t'(9), w);
        wait_toggle(2);
        check_val("chan_clk[2] half period at change", old_div + 1,
                  last_tog[2] - tog_ref);
        tog_ref = last_tog[2];
        repeat (3) wait_toggle(2);
        check_val("chan_clk[2] half periods after change", 3 * (9 + 1),
                  last_tog[2] - tog_ref);

        // Channel 3 off, then on again.
        en_model[3] = 1'b0;
        running[3]  = 1'b0;
        write_reg(EN_ADDR, div_t'(8'h07), w);
        repeat (4) @(negedge master_clk);
        repeat (OFF_WIN) begin
            @(negedge master_clk);
            check_val("chan_clk[3]", 0, chan_clk[3]);
        end
        en_model[3] = 1'b1;
        write_reg(EN_ADDR, div_t'(8'h0f), w);
        while (!running[3]) begin
            @(negedge master_clk);
        end
        check_val("chan_clk[3] first toggle delay", model_div[3] + 3, first_tog[3] - w);

        // Edge counts over a fixed window.
        count_window(0, CNT_WIN);
        check_val("edge_count", expected_edges(CNT_WIN, model_div[0]), edge_count);
        count_window(2, CNT_WIN);
        check_val("edge_count", expected_edges(CNT_WIN, model_div[2]), edge_count);

        // ****************************************************
        // Random dividers with mon_sel switching
        // ****************************************************
        for (int i = 0; i < NUM_CHAN; i++) begin
            en_model[i] = 1'b0;
            running[i]  = 1'b0;
        end
        write_reg(EN_ADDR, div_t'(0), w);
        for (int i = 0; i < NUM_CHAN; i++) begin
            write_reg(reg_addr_t'(i), div_t'($random(seed) & 32'h1f), w);
        end
        for (int i = 0; i < NUM_CHAN; i++) begin
            en_model[i] = 1'b1;
        end
        write_reg(EN_ADDR, div_t'(8'h0f), w);
        ch = $random(seed) & 32'h3;
        count_window(ch, SEL_WIN);
        exp_cnt = expected_edges(SEL_WIN, model_div[ch]);
        for (int k = 1; k < SEL_N; k++) begin
            // The edge that opens each later interval is counted too.
            ch = $random(seed) & 32'h3;
            mon_sel = chan_idx_t'(ch);
            wait_rise(ch);
            exp_cnt = exp_cnt + 1 + expected_edges(SEL_WIN, model_div[ch]);
            repeat (SEL_WIN) @(negedge master_clk);
        end
        check_val("edge_count", exp_cnt, edge_count);

        $display("Test OK");
        $finish;
    end

endmodule

// File: build.f
+incdir+include
source/freq_gen_pkg.sv
source/freq_cfg_regs.sv
source/freq_divider_chan.sv
source/clk_out_monitor.sv
source/multi_freq_gen.sv
tests/tb_multi_freq_gen.sv

// File: Bender.yml
package:
  name: multi_freq_gen

sources:
  # Design sources, package first.
  - files:
      - source/freq_gen_pkg.sv
      - source/freq_cfg_regs.sv
      - source/freq_divider_chan.sv
      - source/clk_out_monitor.sv
      - source/multi_freq_gen.sv

  # Simulation only.
  - target: test
    include_dirs:
      - include
    files:
      - tests/tb_multi_freq_gen.sv
